//--- hw/sonar_macros.svh
`ifndef SONAR_MACROS_SVH
`define SONAR_MACROS_SVH

// sensor channels on the controller
`define SONAR_NUM_CH 4

// trig high time, clocks (short for sim)
`define SONAR_TRIG_CYCLES 16

// echo clocks per centimetre step
`define SONAR_CYCLES_PER_CM 8

// clocks allowed between trig low and echo rise
`define SONAR_ECHO_TIMEOUT 400

// range limit in cm, echo still high here counts as overlong
`define SONAR_MAX_CM 200

`define SONAR_RES_W 16 // result word width

`endif

//--- hw/sonar_bus_pkg.sv
`include "sonar_macros.svh"

// register map seen from the APB side
package sonar_bus_pkg;

    // byte addresses, word aligned
    typedef enum logic [7:0] {
        ADDR_CTRL    = 8'h00, // [3:0] enable, [7:4] start (write one)
        ADDR_STATUS  = 8'h04, // [3:0] done, [7:4] fault, w1c
        ADDR_RESULT0 = 8'h08,
        ADDR_RESULT1 = 8'h0c,
        ADDR_RESULT2 = 8'h10,
        ADDR_RESULT3 = 8'h14
    } sonar_addr_e;

    // status word, fault in the upper nibble
    typedef struct packed {
        logic [`SONAR_NUM_CH-1:0] fault; // result word holds a fault view
        logic [`SONAR_NUM_CH-1:0] done;  // sticky, one per channel
    } sonar_status_t;

endpackage

//--- hw/sonar_meas_pkg.sv
`include "sonar_macros.svh"

// measurement side types
package sonar_meas_pkg;

    // channel sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREPARE,   // clear counters
        ST_TRIGGER,   // trig pin high
        ST_WAIT_ECHO,
        ST_MEASURE,   // echo high, count cm
        ST_STORE,
        ST_DONE
    } sonar_state_e;

    typedef enum logic [3:0] {
        FAULT_NONE     = 4'd0,
        FAULT_NO_ECHO  = 4'd1, // no echo rise before timeout
        FAULT_OVERLONG = 4'd2  // echo still high at max range
    } sonar_fault_e;

    typedef struct packed {
        sonar_fault_e code;
        logic [`SONAR_RES_W-5:0] elapsed_cm; // cm counted before the fault
    } sonar_fault_view_t;

    // same 16 bits, the fault flag picks the view
    typedef union packed {
        logic [`SONAR_RES_W-1:0] distance_cm;
        sonar_fault_view_t       fault;
    } sonar_result_u;

endpackage

//--- hw/sonar_echo_timer.sv
`timescale 1ns/10ps
`include "sonar_macros.svh"

module sonar_echo_timer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    clear,    // zero the cm and wait counters
    input  logic                    trig_run, // high for the whole trigger state
    input  logic                    measure,
    input  logic                    echo,     // raw sensor pin
    output logic                    echo_sync,
    output logic                    trig_done,
    output logic                    timeout,
    output logic                    overlong,
    output logic [`SONAR_RES_W-1:0] cm_count
);
    import sonar_meas_pkg::*;

    localparam int CNT_W  = $bits(sonar_result_u); // cm count fills a result word
    localparam int TRIG_W = $clog2(`SONAR_TRIG_CYCLES + 1);
    localparam int WAIT_W = $clog2(`SONAR_ECHO_TIMEOUT + 1);
    localparam int SUB_W  = $clog2(`SONAR_CYCLES_PER_CM + 1);

    logic              echo_meta;
    logic [TRIG_W-1:0] trig_cnt;
    logic [WAIT_W-1:0] wait_cnt;
    logic [SUB_W-1:0]  sub_cnt; // clocks inside the current cm step

    // two flop sync, both echo edges see the same delay
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            echo_meta <= 1'b0;
            echo_sync <= 1'b0;
        end else begin
            echo_meta <= echo;
            echo_sync <= echo_meta;
        end
    end

    // trigger width, restarts on every entry to the trigger state
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            trig_cnt <= '0;
        else if (!trig_run)
            trig_cnt <= '0;
        else
            trig_cnt <= trig_cnt + 1'b1;
    end

    assign trig_done = trig_run && (trig_cnt == TRIG_W'(`SONAR_TRIG_CYCLES - 1));

    // echo rise timeout, counts after trig drops, held once reached
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            wait_cnt <= '0;
        else if (clear || trig_run)
            wait_cnt <= '0; // retrigger restarts the wait too
        else if (!measure && !timeout)
            wait_cnt <= wait_cnt + 1'b1;
    end

    assign timeout = (wait_cnt == WAIT_W'(`SONAR_ECHO_TIMEOUT - 1));

    // cm counter, one step per CYCLES_PER_CM measure clocks
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sub_cnt  <= '0;
            cm_count <= '0;
        end else if (clear) begin
            sub_cnt  <= '0;
            cm_count <= '0;
        end else if (measure && !overlong) begin
            if (sub_cnt == SUB_W'(`SONAR_CYCLES_PER_CM - 1)) begin
                sub_cnt  <= '0;
                cm_count <= cm_count + 1'b1;
            end else begin
                sub_cnt <= sub_cnt + 1'b1;
            end
        end
    end

    assign overlong = (cm_count == CNT_W'(`SONAR_MAX_CM)); // range limit hit

endmodule

//--- hw/sonar_channel_ctrl.sv
`timescale 1ns/10ps
`include "sonar_macros.svh"

module sonar_channel_ctrl (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         enable,      // level from CTRL
    input  logic                         start,       // one clock pulse
    input  logic                         echo,
    output logic                         trig,
    output logic                         done_pulse,
    output logic                         fault_flag,
    output sonar_meas_pkg::sonar_result_u result_word
);
    import sonar_meas_pkg::*;

    sonar_state_e            state;
    sonar_state_e            state_next;
    sonar_fault_e            fault_code; // why the last measure ended
    sonar_fault_e            fault_next;
    sonar_result_u           word_next;
    logic                    clear;
    logic                    trig_run;
    logic                    measure;
    logic                    echo_sync;
    logic                    trig_done;
    logic                    timeout;
    logic                    overlong;
    logic [`SONAR_RES_W-1:0] cm_count;

    sonar_echo_timer i_timer (
        .clock     (clock),
        .reset     (reset),
        .clear     (clear),
        .trig_run  (trig_run),
        .measure   (measure),
        .echo      (echo),
        .echo_sync (echo_sync),
        .trig_done (trig_done),
        .timeout   (timeout),
        .overlong  (overlong),
        .cm_count  (cm_count)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= ST_IDLE;
            fault_code <= FAULT_NONE;
        end else begin
            state      <= state_next;
            fault_code <= fault_next;
        end
    end

    // next state, a start while waiting sends trig again
    always_comb begin
        state_next = state;
        fault_next = fault_code;
        case (state)
            ST_IDLE:
                if (enable && start)
                    state_next = ST_PREPARE; // armed only while enabled
            ST_PREPARE: begin
                state_next = ST_TRIGGER;
                fault_next = FAULT_NONE;
            end
            ST_TRIGGER:
                if (trig_done)
                    state_next = ST_WAIT_ECHO;
            ST_WAIT_ECHO:
                if (enable && start) begin
                    state_next = ST_TRIGGER; // retrigger
                end else if (echo_sync) begin
                    state_next = ST_MEASURE;
                end else if (timeout) begin
                    state_next = ST_STORE;
                    fault_next = FAULT_NO_ECHO;
                end
            ST_MEASURE:
                if (!echo_sync) begin
                    state_next = ST_STORE; // echo fell, normal end
                end else if (overlong) begin
                    state_next = ST_STORE;
                    fault_next = FAULT_OVERLONG;
                end
            ST_STORE: state_next = ST_DONE;
            ST_DONE:  state_next = ST_IDLE;
            default:  state_next = ST_IDLE;
        endcase
    end

    assign clear      = (state == ST_PREPARE);
    assign trig_run   = (state == ST_TRIGGER);
    assign measure    = (state == ST_MEASURE);
    assign trig       = trig_run;
    assign done_pulse = (state == ST_DONE); // rises at the store to done edge

    // pick the union view from the fault code
    always_comb begin
        word_next = '0;
        if (fault_code == FAULT_NONE) begin
            word_next.distance_cm = cm_count;
        end else begin
            word_next.fault.code       = fault_code;
            word_next.fault.elapsed_cm = cm_count[$bits(word_next.fault.elapsed_cm)-1:0];
        end
    end

    // result held from store until the next store
    always_ff @(posedge clock) begin
        if (state == ST_STORE)
            result_word <= word_next;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            fault_flag <= 1'b0;
        else if (state == ST_STORE)
            fault_flag <= (fault_code != FAULT_NONE);
    end

    // every trig pulse lasts exactly the trigger width
    a_trig_width: assert property (@(posedge clock) disable iff (reset)
        $rose(trig) |-> trig [*`SONAR_TRIG_CYCLES] ##1 !trig);

endmodule

//--- hw/sonar_apb_regs.sv
`timescale 1ns/10ps
`include "sonar_macros.svh"

module sonar_apb_regs (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [7:0]                              paddr,
    input  logic [31:0]                             pwdata,
    output logic [31:0]                             prdata,
    output logic                                    pslverr,
    input  sonar_bus_pkg::sonar_status_t            status,
    input  logic [`SONAR_NUM_CH-1:0][`SONAR_RES_W-1:0] results,
    output logic [`SONAR_NUM_CH-1:0]                enable,
    output logic [`SONAR_NUM_CH-1:0]                start,
    output logic [`SONAR_NUM_CH-1:0]                clear_mask
);
    import sonar_bus_pkg::*;

    localparam int N = `SONAR_NUM_CH;

    logic access;    // zero wait, access phase always completes
    logic wr_ctrl;
    logic wr_status;
    logic addr_ok;
    logic is_result; // result registers are read only

    assign access    = psel && penable;
    assign wr_ctrl   = access && pwrite && (paddr == ADDR_CTRL);
    assign wr_status = access && pwrite && (paddr == ADDR_STATUS);

    // read mux and decode
    always_comb begin
        prdata    = '0;
        addr_ok   = 1'b1;
        is_result = 1'b0;
        case (sonar_addr_e'(paddr))
            ADDR_CTRL:    prdata = 32'(enable); // start bits read back zero
            ADDR_STATUS:  prdata = 32'(status);
            ADDR_RESULT0: begin
                prdata    = 32'(results[0]);
                is_result = 1'b1;
            end
            ADDR_RESULT1: begin
                prdata    = 32'(results[1]);
                is_result = 1'b1;
            end
            ADDR_RESULT2: begin
                prdata    = 32'(results[2]);
                is_result = 1'b1;
            end
            ADDR_RESULT3: begin
                prdata    = 32'(results[3]);
                is_result = 1'b1;
            end
            default:      addr_ok = 1'b0;
        endcase
    end

    assign pslverr = access && (!addr_ok || (pwrite && is_result));

    // enable level, start and clear become one clock pulses
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            enable     <= '0;
            start      <= '0;
            clear_mask <= '0;
        end else begin
            start      <= '0;
            clear_mask <= '0;
            if (wr_ctrl) begin
                enable <= pwdata[N-1:0];
                start  <= pwdata[2*N-1:N];
            end
            // a one on either the done or the fault bit clears the channel
            if (wr_status)
                clear_mask <= pwdata[N-1:0] | pwdata[2*N-1:N];
        end
    end

    // access phase only ever follows a setup phase
    a_apb_setup: assert property (@(posedge clock) disable iff (reset)
        penable |-> psel && $past(psel && !penable));

endmodule

//--- hw/sonar_result_collect.sv
`timescale 1ns/10ps
`include "sonar_macros.svh"

module sonar_result_collect (
    input  logic                                       clock,
    input  logic                                       reset,
    input  logic [`SONAR_NUM_CH-1:0]                   done_pulse,
    input  logic [`SONAR_NUM_CH-1:0]                   fault_flag,
    input  sonar_meas_pkg::sonar_result_u [`SONAR_NUM_CH-1:0] result_word,
    input  logic [`SONAR_NUM_CH-1:0]                   clear_mask,
    output sonar_bus_pkg::sonar_status_t               status,
    output logic [`SONAR_NUM_CH-1:0][`SONAR_RES_W-1:0] results,
    output logic                                       irq
);
    import sonar_bus_pkg::*;
    import sonar_meas_pkg::*;

    // latest result per channel, no overrun tracking
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            status  <= '0;
            results <= '0;
        end else begin
            for (int i = 0; i < `SONAR_NUM_CH; i++) begin
                if (done_pulse[i]) begin // set beats clear
                    status.done[i]  <= 1'b1;
                    status.fault[i] <= fault_flag[i];
                    results[i]      <= result_word[i];
                end else if (clear_mask[i]) begin
                    status.done[i]  <= 1'b0;
                    status.fault[i] <= 1'b0;
                end
            end
        end
    end

    assign irq = |status.done; // level, until software clears

    // done only drops through a STATUS write from the register block
    for (genvar g = 0; g < `SONAR_NUM_CH; g++) begin : g_chk
        a_done_sticky: assert property (@(posedge clock) disable iff (reset)
            $fell(status.done[g]) |-> $past(clear_mask[g]));
    end

endmodule

//--- hw/sonar_top.sv
`timescale 1ns/10ps
`include "sonar_macros.svh"

module sonar_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [7:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pslverr,
    output logic [`SONAR_NUM_CH-1:0] trig,
    input  logic [`SONAR_NUM_CH-1:0] echo,
    output logic                     irq
);
    import sonar_bus_pkg::*;
    import sonar_meas_pkg::*;

    logic [`SONAR_NUM_CH-1:0]                   enable;
    logic [`SONAR_NUM_CH-1:0]                   start;
    logic [`SONAR_NUM_CH-1:0]                   clear_mask;
    logic [`SONAR_NUM_CH-1:0]                   done_pulse;
    logic [`SONAR_NUM_CH-1:0]                   fault_flag;
    sonar_result_u [`SONAR_NUM_CH-1:0]          result_word;
    sonar_status_t                              status;
    logic [`SONAR_NUM_CH-1:0][`SONAR_RES_W-1:0] results;

    sonar_apb_regs i_regs (
        .clock      (clock),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .status     (status),
        .results    (results),
        .enable     (enable),
        .start      (start),
        .clear_mask (clear_mask)
    );

    // one sequencer per sensor
    for (genvar c = 0; c < `SONAR_NUM_CH; c++) begin : g_ch
        sonar_channel_ctrl i_ch (
            .clock       (clock),
            .reset       (reset),
            .enable      (enable[c]),
            .start       (start[c]),
            .echo        (echo[c]),
            .trig        (trig[c]),
            .done_pulse  (done_pulse[c]),
            .fault_flag  (fault_flag[c]),
            .result_word (result_word[c])
        );
    end

    sonar_result_collect i_collect (
        .clock       (clock),
        .reset       (reset),
        .done_pulse  (done_pulse),
        .fault_flag  (fault_flag),
        .result_word (result_word),
        .clear_mask  (clear_mask),
        .status      (status),
        .results     (results),
        .irq         (irq)
    );

endmodule

//--- testbench/sonar_sensor_model.sv
`timescale 1ns/10ps

module sonar_sensor_model (
    input  logic clock,
    input  logic reset,
    input  logic trig,
    input  int   delay_clk,   // clocks from trig fall to echo rise
    input  int   len_clk,     // echo high time in clocks
    input  logic silent,      // sensor never answers
    output logic echo,
    output int   pulse_count, // trig pulses seen so far
    output int   last_width   // high time of the last trig pulse
);
    logic trig_q;
    logic pending;   // echo scheduled, still in the delay
    int   width;
    int   wait_left;
    int   high_left;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            trig_q      <= 1'b0;
            pending     <= 1'b0;
            echo        <= 1'b0;
            width       <= 0;
            wait_left   <= 0;
            high_left   <= 0;
            pulse_count <= 0;
            last_width  <= 0;
        end else begin
            trig_q <= trig;
            if (trig)
                width <= width + 1;
            if (trig_q && !trig) begin // trig fell, drops any echo still due
                last_width  <= width;
                width       <= 0;
                pulse_count <= pulse_count + 1;
                echo        <= 1'b0;
                high_left   <= 0;
                pending     <= !silent;
                wait_left   <= delay_clk;
            end else if (pending) begin
                if (wait_left <= 1) begin
                    pending   <= 1'b0;
                    echo      <= 1'b1;
                    high_left <= len_clk;
                end else begin
                    wait_left <= wait_left - 1;
                end
            end else if (high_left > 0) begin
                if (high_left == 1)
                    echo <= 1'b0; // echo ends after len_clk clocks
                high_left <= high_left - 1;
            end
        end
    end

endmodule

//--- testbench/sonar_tb.sv
`timescale 1ns/10ps
`include "sonar_macros.svh"

module sonar_tb;
    import sonar_bus_pkg::*;
    import sonar_meas_pkg::*;

    localparam int N         = `SONAR_NUM_CH;
    localparam int MEAS_CLKS = `SONAR_TRIG_CYCLES + `SONAR_ECHO_TIMEOUT
                               + `SONAR_MAX_CM * `SONAR_CYCLES_PER_CM;
    localparam int NUM_MEAS  = 10; // measurements over all tests
    localparam int LIMIT_NS  = NUM_MEAS * MEAS_CLKS * 2 * 8;

    logic         clock;
    logic         reset;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [7:0]   paddr;
    logic [31:0]  pwdata;
    logic [31:0]  prdata;
    logic         pslverr;
    logic [N-1:0] trig;
    logic [N-1:0] echo;
    logic         irq;
    int           sens_delay [N];
    int           sens_len [N];
    logic         sens_silent [N];
    int           pulse_count [N];
    int           last_width [N];
    logic [31:0]  lfsr;
    int           errors;
    int           checks;
    int           tests;
    int           passed;
    int           err_mark;   // error count when the current test began
    logic [15:0]  exp_word [N];
    logic         exp_fault [N];
    logic [N-1:0] check_mask; // channels the compare process looks at
    event         check_req;
    event         check_ack;

    sonar_top i_dut (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .trig    (trig),
        .echo    (echo),
        .irq     (irq)
    );

    for (genvar c = 0; c < N; c++) begin : g_sens
        sonar_sensor_model i_sensor (
            .clock       (clock),
            .reset       (reset),
            .trig        (trig[c]),
            .delay_clk   (sens_delay[c]),
            .len_clk     (sens_len[c]),
            .silent      (sens_silent[c]),
            .echo        (echo[c]),
            .pulse_count (pulse_count[c]),
            .last_width  (last_width[c])
        );
    end

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock; // 8 ns period
    end

    // galois lfsr, one step per bit taken
    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            val  = (val << 1) | int'(lfsr[0]);
        end
        return val;
    endfunction

    // expected {fault, word} for one echo
    function automatic logic [16:0] expected_result(input logic silent, input int delay_clk,
                                                    input int len_clk);
        sonar_result_u w;
        logic          fault;
        w     = '0;
        fault = 1'b0;
        // echo reaches the FSM 4 clocks after the model's delay ends
        if (silent || delay_clk > `SONAR_ECHO_TIMEOUT - 4) begin
            fault        = 1'b1;
            w.fault.code = FAULT_NO_ECHO;
        end else if (len_clk >= `SONAR_MAX_CM * `SONAR_CYCLES_PER_CM + 2) begin
            fault              = 1'b1; // still high once the last cm step is counted
            w.fault.code       = FAULT_OVERLONG;
            w.fault.elapsed_cm = 12'(`SONAR_MAX_CM);
        end else begin
            w.distance_cm = 16'(len_clk / `SONAR_CYCLES_PER_CM); // rounded down
        end
        return {fault, w};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one zero wait APB transfer, read data taken mid access phase
    task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clock);
        psel    <= 1'b1; // setup
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1; // access
        @(negedge clock);
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value("pslverr", 32'(err), 32'(exp_err));
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic read_check(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        read_reg(addr, rd, err);
        check_value(name, rd, exp);
        check_value("pslverr", 32'(err), 32'h0);
    endtask

    // poll STATUS until every channel in mask is done
    task automatic wait_done(input logic [N-1:0] mask);
        logic [31:0] st;
        logic        err;
        for (int i = 0; i < MEAS_CLKS; i++) begin
            read_reg(ADDR_STATUS, st, err);
            if ((st[N-1:0] & mask) == mask)
                return;
        end
        errors++;
        $display("done bits %b never came up in STATUS", mask);
    endtask

    task automatic wait_pulse(input int c, input int target);
        for (int i = 0; i < MEAS_CLKS; i++) begin
            @(negedge clock);
            if (pulse_count[c] >= target)
                return;
        end
        errors++;
        $display("no trig pulse seen on channel %0d", c);
    endtask

    // sensor setup plus what the channel should report
    task automatic setup_channel(input int c, input logic silent, input int delay_clk,
                                 input int len_clk);
        logic [16:0] e;
        e              = expected_result(silent, delay_clk, len_clk);
        exp_fault[c]   = e[16];
        exp_word[c]    = e[15:0];
        sens_silent[c] <= silent;
        sens_delay[c]  <= delay_clk;
        sens_len[c]    <= len_clk;
    endtask

    task automatic run_and_compare(input logic [N-1:0] mask);
        check_mask = mask;
        -> check_req;
        @(check_ack); // compare process done with this batch
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark)
            passed++;
        $display("test %s: %s", name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    // reads results once STATUS says done
    initial begin : compare
        logic [31:0] st;
        logic        err;
        forever begin
            @(check_req);
            wait_done(check_mask);
            read_reg(ADDR_STATUS, st, err);
            for (int c = 0; c < N; c++) begin
                if (check_mask[c]) begin
                    read_check($sformatf("RESULT%0d", c), 8'(ADDR_RESULT0 + 4 * c),
                               32'(exp_word[c]));
                    check_value($sformatf("STATUS.fault[%0d]", c), 32'(st[N + c]),
                                32'(exp_fault[c]));
                end
            end
            -> check_ack;
        end
    end

    initial begin : watchdog
        #(LIMIT_NS);
        $display("watchdog ran out before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        int pc;
        lfsr     = 32'd84488;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        passed   = 0;
        err_mark = 0;
        reset    <= 1'b1;
        psel     <= 1'b0;
        penable  <= 1'b0;
        pwrite   <= 1'b0;
        paddr    <= '0;
        pwdata   <= '0;
        for (int c = 0; c < N; c++)
            setup_channel(c, 1'b1, 1, 1);
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        read_check("CTRL", ADDR_CTRL, 0);
        read_check("STATUS", ADDR_STATUS, 0);
        for (int c = 0; c < N; c++)
            read_check($sformatf("RESULT%0d", c), 8'(ADDR_RESULT0 + 4 * c), 0);
        @(negedge clock);
        check_value("trig", 32'(trig), 0);
        check_value("irq", 32'(irq), 0);
        begin : bad_access
            logic [31:0] rd;
            logic        err;
            read_reg(8'h40, rd, err); // unmapped
            check_value("pslverr", 32'(err), 1);
        end
        apb_write(ADDR_RESULT1, 32'h1234, 1'b1); // read only
        read_check("RESULT1", ADDR_RESULT1, 0);
        end_test("reset");

        setup_channel(0, 1'b0, 5, 123);
        apb_write(ADDR_CTRL, 32'h11, 1'b0);
        run_and_compare(4'b0001);
        @(negedge clock);
        check_value("trig[0] width", 32'(last_width[0]), `SONAR_TRIG_CYCLES);
        check_value("irq", 32'(irq), 1);
        end_test("single");

        apb_write(ADDR_STATUS, 32'hff, 1'b0);
        for (int c = 0; c < N; c++)
            setup_channel(c, 1'b0, 1 + rand_bits(5), 8 + rand_bits(10));
        apb_write(ADDR_CTRL, 32'hff, 1'b0); // all enabled, all started
        run_and_compare(4'b1111);
        read_check("STATUS", ADDR_STATUS, 32'h0f);
        end_test("parallel");

        apb_write(ADDR_STATUS, 32'hff, 1'b0);
        setup_channel(0, 1'b1, 5, 0);
        setup_channel(1, 1'b0, 5, `SONAR_MAX_CM * `SONAR_CYCLES_PER_CM + 400);
        apb_write(ADDR_CTRL, 32'h3f, 1'b0);
        run_and_compare(4'b0011);
        read_check("STATUS", ADDR_STATUS, 32'h33);
        end_test("faults");

        apb_write(ADDR_STATUS, 32'h11, 1'b0); // clear channel 0 only
        read_check("STATUS", ADDR_STATUS, 32'h22);
        @(negedge clock);
        check_value("irq", 32'(irq), 1);
        apb_write(ADDR_STATUS, 32'h22, 1'b0);
        read_check("STATUS", ADDR_STATUS, 0);
        @(negedge clock);
        check_value("irq", 32'(irq), 0);
        pc = pulse_count[3];
        apb_write(ADDR_CTRL, 32'h87, 1'b0); // channel 3 off but started
        repeat (4 * `SONAR_TRIG_CYCLES) @(posedge clock);
        check_value("trig[3] pulses", pulse_count[3], pc);
        read_check("STATUS", ADDR_STATUS, 0);
        end_test("control");

        pc = pulse_count[2];
        setup_channel(2, 1'b0, 300, 50); // first echo comes late
        apb_write(ADDR_CTRL, 32'h47, 1'b0);
        wait_pulse(2, pc + 1);
        setup_channel(2, 1'b0, 20, 333);
        apb_write(ADDR_CTRL, 32'h47, 1'b0); // second start during wait_echo
        run_and_compare(4'b0100);
        check_value("trig[2] pulses", pulse_count[2], pc + 2);
        end_test("retrigger");

        $display("tests %0d, passed %0d, checks %0d, errors %0d", tests, passed, checks,
                 errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sonar_top.f
+incdir+hw
hw/sonar_bus_pkg.sv
hw/sonar_meas_pkg.sv
hw/sonar_echo_timer.sv
hw/sonar_channel_ctrl.sv
hw/sonar_apb_regs.sv
hw/sonar_result_collect.sv
hw/sonar_top.sv
testbench/sonar_sensor_model.sv
testbench/sonar_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the sonar testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert \
    --top-module sonar_tb \
    -f sonar_top.f \
    --Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vsonar_tb" | tee "$log"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if [ ! -s "$log" ]; then
    echo "no simulation log written"
    exit 1
fi

if grep -q "Result: FAILED" "$log"; then
    exit 1
fi
exit 0
